//--- common/armCtrlPkg.sv
package armCtrlPkg;

  // ==================================================
  // Vector types
  // ==================================================
  typedef logic [31:0] instrT;     // Raw instruction word
  typedef logic [3:0]  condT;      // Bits 31:28
  typedef logic [3:0]  flagsT;     // N Z C V, N on top
  typedef logic [3:0]  aluCtrlT;   // DP opcode
  typedef logic [3:0]  byteMaskT;  // One bit per byte lane
  typedef logic [1:0]  flagWriteT; // [1] NZ, [0] CV

  // ==================================================
  // Condition field encodings
  // ==================================================
  localparam condT condEq = 4'b0000;  // Z set
  localparam condT condNe = 4'b0001;
  localparam condT condCs = 4'b0010;  // Unsigned higher or same
  localparam condT condCc = 4'b0011;
  localparam condT condMi = 4'b0100;
  localparam condT condPl = 4'b0101;
  localparam condT condVs = 4'b0110;
  localparam condT condVc = 4'b0111;
  localparam condT condHi = 4'b1000;
  localparam condT condLs = 4'b1001;
  localparam condT condGe = 4'b1010;  // Signed compares
  localparam condT condLt = 4'b1011;
  localparam condT condGt = 4'b1100;
  localparam condT condLe = 4'b1101;
  localparam condT condAl = 4'b1110;  // Always

  // ALU ops forced for address generation
  localparam aluCtrlT aluAdd = 4'b0100;
  localparam aluCtrlT aluSub = 4'b0010;

  // Instruction class, bits 27:26
  localparam logic [1:0] classDp  = 2'b00;
  localparam logic [1:0] classMem = 2'b01;
  localparam logic [1:0] classBr  = 2'b10;

endpackage

//--- decode/instrDecoder.sv
module instrDecoder import armCtrlPkg::*; (
  input  instrT      InstrD,
  output logic [1:0] RegSrcD,      // Register port source select
  output logic [1:0] ImmSrcD,      // Immediate extend select
  output logic       AluSrcD,
  output logic       MemtoRegD,
  output logic       RegWriteD,
  output logic       MemWriteD,
  output logic       BranchD,
  output logic       ByteAccessD,
  output aluCtrlT    AluControlD,
  output flagWriteT  FlagWriteD,
  output logic       PcSrcD
);

  logic [9:0] controlsD;     // Packed main decode word
  logic       regWriteRawD;  // Before compare kill
  logic       aluOpD;        // Opcode passes to ALU
  logic       memClassD;
  logic       cmpTypeD;

  // ==================================================
  // Main decoder
  // ==================================================
  // Word layout RegSrc_ImmSrc_AluSrc_MemtoReg_RegWrite_MemWrite_Branch_AluOp
  always_comb begin
    case (InstrD[27:26])
      classDp: begin
        if (InstrD[25]) begin
          controlsD = 10'b00_00_1_0_1_0_0_1;  // DP immediate operand
        end else begin
          controlsD = 10'b00_00_0_0_1_0_0_1;  // DP register operand
        end
      end
      classMem: begin
        // I bit set means register offset here
        case ({InstrD[20], InstrD[25]})
          2'b10:   controlsD = 10'b00_01_1_1_1_0_0_0;  // LDR imm
          2'b11:   controlsD = 10'b00_01_0_1_1_0_0_0;  // LDR reg
          2'b00:   controlsD = 10'b10_01_1_0_0_1_0_0;  // STR imm
          default: controlsD = 10'b10_01_0_0_0_1_0_0;  // STR reg
        endcase
      end
      classBr:  controlsD = 10'b01_10_1_0_0_0_1_0;  // B
      default:  controlsD = '0;                     // Coproc and SWI space unused
    endcase
  end

  assign {RegSrcD, ImmSrcD, AluSrcD, MemtoRegD,
          regWriteRawD, MemWriteD, BranchD, aluOpD} = controlsD;

  assign memClassD = (InstrD[27:26] == classMem);

  // ==================================================
  // ALU decoder
  // ==================================================
  always_comb begin
    if (memClassD) begin
      // U bit picks offset direction
      AluControlD = InstrD[23] ? aluAdd : aluSub;
      FlagWriteD  = 2'b00;
    end else if (aluOpD) begin
      AluControlD = InstrD[24:21];      // Opcode straight through
      FlagWriteD  = {2{InstrD[20]}};    // S bit
    end else begin
      AluControlD = aluAdd;             // Branch target sum
      FlagWriteD  = 2'b00;
    end
  end

  // TST TEQ CMP CMN only touch flags
  assign cmpTypeD  = aluOpD & (InstrD[24:23] == 2'b10);
  assign RegWriteD = regWriteRawD & ~cmpTypeD;

  assign ByteAccessD = memClassD & InstrD[22];  // B bit of LDRB/STRB

  // Write to R15 redirects fetch
  assign PcSrcD = RegWriteD & (InstrD[15:12] == 4'hf);

endmodule

//--- execute/executeStage.sv
module executeStage import armCtrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        StallE,
  input  logic        FlushE,
  input  instrT       InstrD,
  input  logic        AluSrcD,
  input  aluCtrlT     AluControlD,
  input  flagWriteT   FlagWriteD,
  input  logic        BranchD,
  input  logic        RegWriteD,
  input  logic        MemWriteD,
  input  logic        MemtoRegD,
  input  logic        PcSrcD,
  input  logic        ByteAccessD,
  input  flagsT       FlagsE,       // Forwarded flags
  input  logic [31:0] ALUResultE,   // Store address
  output logic        AluSrcE,
  output aluCtrlT     AluControlE,
  output flagWriteT   FlagWriteE,
  output logic        CondExE,
  output logic        BranchTakenE,
  output logic        RegWriteGatedE,
  output logic        MemWriteGatedE,
  output logic        MemtoRegE,
  output logic        PcSrcGatedE,
  output byteMaskT    ByteMaskE
);

  localparam int CtrlW = 17;

  logic [CtrlW-1:0] ctrlD;
  logic [CtrlW-1:0] ctrlE;
  condT             condE;
  logic             branchE;
  logic             regWriteE;
  logic             memWriteE;
  logic             pcSrcE;
  logic             byteAccessE;
  logic             nFlag, zFlag, cFlag, vFlag;

  // ==================================================
  // Decode to Execute register
  // ==================================================
  assign ctrlD = {InstrD[31:28], AluSrcD, AluControlD, FlagWriteD, BranchD,
                  RegWriteD, MemWriteD, MemtoRegD, PcSrcD, ByteAccessD};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (FlushE) begin
      ctrlE <= '0;                // Bubble
    end else if (!StallE) begin
      ctrlE <= ctrlD;
    end
  end

  assign {condE, AluSrcE, AluControlE, FlagWriteE, branchE,
          regWriteE, memWriteE, MemtoRegE, pcSrcE, byteAccessE} = ctrlE;

  // ==================================================
  // Condition check
  // ==================================================
  assign {nFlag, zFlag, cFlag, vFlag} = FlagsE;

  always_comb begin
    case (condE)
      condEq:  CondExE = zFlag;
      condNe:  CondExE = ~zFlag;
      condCs:  CondExE = cFlag;
      condCc:  CondExE = ~cFlag;
      condMi:  CondExE = nFlag;
      condPl:  CondExE = ~nFlag;
      condVs:  CondExE = vFlag;
      condVc:  CondExE = ~vFlag;
      condHi:  CondExE = cFlag & ~zFlag;
      condLs:  CondExE = ~cFlag | zFlag;
      condGe:  CondExE = (nFlag == vFlag);
      condLt:  CondExE = (nFlag != vFlag);
      condGt:  CondExE = ~zFlag & (nFlag == vFlag);
      condLe:  CondExE = zFlag | (nFlag != vFlag);
      condAl:  CondExE = 1'b1;
      default: CondExE = 1'b0;    // 1111 never executes here
    endcase
  end

  // Failed condition turns the instruction into a no-op
  assign BranchTakenE   = branchE & CondExE;
  assign RegWriteGatedE = regWriteE & CondExE;
  assign MemWriteGatedE = memWriteE & CondExE;
  assign PcSrcGatedE    = pcSrcE & CondExE;

  // ==================================================
  // Store lane mask
  // ==================================================
  always_comb begin
    if (!MemWriteGatedE) begin
      ByteMaskE = 4'b0000;                          // No store, no lanes
    end else if (byteAccessE) begin
      ByteMaskE = 4'b0001 << ALUResultE[1:0];       // STRB lane
    end else begin
      ByteMaskE = 4'b1111;                          // Full word
    end
  end

endmodule

//--- logic/memWbPipe.sv
module memWbPipe import armCtrlPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     StallM,
  input  logic     FlushM,
  input  logic     StallW,
  input  logic     FlushW,
  input  logic     RegWriteGatedE,
  input  logic     MemWriteGatedE,
  input  logic     MemtoRegE,
  input  logic     PcSrcGatedE,
  input  byteMaskT ByteMaskE,
  output logic     RegWriteM,
  output logic     MemWriteM,
  output logic     MemtoRegM,
  output byteMaskT ByteMaskM,
  output logic     MemtoRegW,
  output logic     RegWriteW,
  output logic     PcSrcW
);

  logic [7:0] bankM;   // RegWrite MemWrite MemtoReg PcSrc mask
  logic [2:0] bankW;   // MemtoReg RegWrite PcSrc
  logic       pcSrcM;

  // ==================================================
  // Memory stage
  // ==================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bankM <= '0;
    end else if (FlushM) begin
      bankM <= '0;
    end else if (!StallM) begin
      bankM <= {RegWriteGatedE, MemWriteGatedE, MemtoRegE, PcSrcGatedE, ByteMaskE};
    end
  end

  assign {RegWriteM, MemWriteM, MemtoRegM, pcSrcM, ByteMaskM} = bankM;

  // ==================================================
  // Writeback stage
  // ==================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bankW <= '0;
    end else if (FlushW) begin
      bankW <= '0;                 // Flush beats stall
    end else if (!StallW) begin
      bankW <= {MemtoRegM, RegWriteM, pcSrcM};
    end
  end

  assign {MemtoRegW, RegWriteW, PcSrcW} = bankW;

endmodule

//--- logic/flagTracker.sv
module flagTracker import armCtrlPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      StallM,
  input  logic      FlushM,
  input  logic      StallW,
  input  logic      FlushW,
  input  flagWriteT FlagWriteE,
  input  logic      CondExE,
  input  flagsT     ALUFlagsE,
  output flagsT     FlagsE
);

  flagsT flagsNextE;   // Current flags with ALU result merged in
  logic  setE;
  flagsT flagsM, flagsW;
  logic  setM, setW;
  flagsT nzcvQ;        // Committed NZCV

  // Partial update keeps the untouched pair
  assign flagsNextE = {FlagWriteE[1] ? ALUFlagsE[3:2] : FlagsE[3:2],
                       FlagWriteE[0] ? ALUFlagsE[1:0] : FlagsE[1:0]};
  assign setE       = (|FlagWriteE) & CondExE;

  // ==================================================
  // Pending flags in Memory and Writeback
  // ==================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {flagsM, setM} <= '0;
      {flagsW, setW} <= '0;
    end else begin
      if (FlushM) {flagsM, setM} <= '0;
      else if (!StallM) {flagsM, setM} <= {flagsNextE, setE};
      if (FlushW) {flagsW, setW} <= '0;
      else if (!StallW) {flagsW, setW} <= {flagsM, setM};
    end
  end

  // Commit as the setter leaves Writeback
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      nzcvQ <= '0;
    end else if (setW && !StallW) begin
      nzcvQ <= flagsW;
    end
  end

  // Youngest pending update wins
  assign FlagsE = setM ? flagsM : (setW ? flagsW : nzcvQ);

endmodule

//--- logic/armController.sv
module armController import armCtrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  instrT       InstrD,
  input  flagsT       ALUFlagsE,
  input  logic [31:0] ALUResultE,
  input  logic        StallE,
  input  logic        FlushE,
  input  logic        StallM,
  input  logic        FlushM,
  input  logic        StallW,
  input  logic        FlushW,
  output logic [1:0]  RegSrcD,
  output logic [1:0]  ImmSrcD,
  output logic        AluSrcE,
  output aluCtrlT     AluControlE,
  output logic        BranchTakenE,
  output flagsT       FlagsE,
  output logic        RegWriteM,
  output logic        MemWriteM,
  output logic        MemtoRegM,
  output byteMaskT    ByteMaskM,
  output logic        MemtoRegW,
  output logic        RegWriteW,
  output logic        PcSrcW
);

  // Decode controls
  logic      aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, byteAccessD, pcSrcD;
  aluCtrlT   aluControlD;
  flagWriteT flagWriteD;
  // Gated Execute controls
  flagWriteT flagWriteE;
  logic      condExE, regWriteGatedE, memWriteGatedE, memtoRegE, pcSrcGatedE;
  byteMaskT  byteMaskE;

  instrDecoder i_instrDecoder (
    .InstrD, .RegSrcD, .ImmSrcD,
    .AluSrcD(aluSrcD), .MemtoRegD(memtoRegD), .RegWriteD(regWriteD),
    .MemWriteD(memWriteD), .BranchD(branchD), .ByteAccessD(byteAccessD),
    .AluControlD(aluControlD), .FlagWriteD(flagWriteD), .PcSrcD(pcSrcD)
  );

  executeStage i_executeStage (
    .clk, .rstN, .StallE, .FlushE, .InstrD,
    .AluSrcD(aluSrcD), .AluControlD(aluControlD), .FlagWriteD(flagWriteD),
    .BranchD(branchD), .RegWriteD(regWriteD), .MemWriteD(memWriteD),
    .MemtoRegD(memtoRegD), .PcSrcD(pcSrcD), .ByteAccessD(byteAccessD),
    .FlagsE, .ALUResultE, .AluSrcE, .AluControlE,
    .FlagWriteE(flagWriteE), .CondExE(condExE), .BranchTakenE,
    .RegWriteGatedE(regWriteGatedE), .MemWriteGatedE(memWriteGatedE),
    .MemtoRegE(memtoRegE), .PcSrcGatedE(pcSrcGatedE), .ByteMaskE(byteMaskE)
  );

  memWbPipe i_memWbPipe (
    .clk, .rstN, .StallM, .FlushM, .StallW, .FlushW,
    .RegWriteGatedE(regWriteGatedE), .MemWriteGatedE(memWriteGatedE),
    .MemtoRegE(memtoRegE), .PcSrcGatedE(pcSrcGatedE), .ByteMaskE(byteMaskE),
    .RegWriteM, .MemWriteM, .MemtoRegM, .ByteMaskM,
    .MemtoRegW, .RegWriteW, .PcSrcW
  );

  // Flags loop back into the condition check
  flagTracker i_flagTracker (
    .clk, .rstN, .StallM, .FlushM, .StallW, .FlushW,
    .FlagWriteE(flagWriteE), .CondExE(condExE), .ALUFlagsE, .FlagsE
  );

endmodule

//--- verification/clockGen.sv
module clockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk  = 1'b0;
    rstN = 1'b0;               // Held over the first two rising edges
    repeat (2) @(negedge clk);
    rstN = 1'b1;               // Released on a falling edge
  end

  always #10 clk = ~clk;       // Period 20

endmodule

//--- verification/armController_asserts.sv
module armControllerAsserts import armCtrlPkg::*; (
  input logic        clk,
  input logic        rstN,
  input instrT       InstrD,
  input flagsT       ALUFlagsE,
  input logic [31:0] ALUResultE,
  input logic        StallE, FlushE, StallM, FlushM, StallW, FlushW,
  input logic [1:0]  RegSrcD, ImmSrcD,
  input logic        AluSrcE,
  input aluCtrlT     AluControlE,
  input logic        BranchTakenE,
  input flagsT       FlagsE,
  input logic        RegWriteM, MemWriteM, MemtoRegM,
  input byteMaskT    ByteMaskM,
  input logic        MemtoRegW, RegWriteW, PcSrcW
);

  int          failCount = 0;  // Read by the testbench
  logic        quiet;          // No stall or flush anywhere
  logic        isAlD, isBrD, isDpSD, isCmpD, isStoreD, isLdrD;
  logic [10:0] ctrlOuts;
  instrT       instrQ;         // InstrD one edge back
  flagsT       flagsQ;
  logic [31:0] resQ;

  assign quiet    = !(StallE || FlushE || StallM || FlushM || StallW || FlushW);
  assign isAlD    = (InstrD[31:28] == condAl);
  assign isBrD    = (InstrD[27:26] == classBr);
  assign isDpSD   = (InstrD[27:26] == classDp) && InstrD[20];   // S bit set
  assign isCmpD   = isDpSD && (InstrD[24:21] == 4'b1010);
  assign isStoreD = (InstrD[27:26] == classMem) && !InstrD[20];
  assign isLdrD   = (InstrD[27:26] == classMem) && InstrD[20];
  assign ctrlOuts = {BranchTakenE, RegWriteM, MemWriteM, MemtoRegM, ByteMaskM,
                     MemtoRegW, RegWriteW, PcSrcW};

  always_ff @(posedge clk) begin
    instrQ <= InstrD;
    flagsQ <= ALUFlagsE;   // Flags of the op in Execute
    resQ   <= ALUResultE;
  end

  // ==================================================
  // Reset and branch
  // ==================================================
  resetQuiet: assert property (@(posedge clk) (!rstN || !$past(rstN)) |-> ctrlOuts == '0)
    else begin
      failCount++;
      $error("mismatch reset expected 0 actual %b", $sampled(ctrlOuts));
    end

  branchAlways: assert property (@(posedge clk) disable iff (!rstN)
      isBrD && isAlD && quiet |=> BranchTakenE)
    else begin
      failCount++;
      $error("mismatch branchAl expected 1 actual %b", $sampled(BranchTakenE));
    end

  branchEq: assert property (@(posedge clk) disable iff (!rstN)
      isBrD && InstrD[31:28] == condEq && quiet |=> BranchTakenE == FlagsE[2])
    else begin
      failCount++;
      $error("mismatch branchEq expected %b actual %b", $sampled(FlagsE[2]),
             $sampled(BranchTakenE));
    end

  // Branch reads PC and takes imm24, store reads Rd and takes imm12
  srcSelects: assert property (@(posedge clk) disable iff (!rstN)
      isStoreD || isBrD |-> {RegSrcD, ImmSrcD} == (isBrD ? 4'b0110 : 4'b1001))
    else begin
      failCount++;
      $error("mismatch srcSelect expected %b actual %b",
             $sampled(isBrD ? 4'b0110 : 4'b1001), $sampled({RegSrcD, ImmSrcD}));
    end

  // ==================================================
  // Flags
  // ==================================================
  // New flags visible once the setter sits in Memory
  flagsForward: assert property (@(posedge clk) disable iff (!rstN)
      isDpSD && isAlD && quiet ##1 quiet |=> FlagsE == flagsQ)
    else begin
      failCount++;
      $error("mismatch flags expected %h actual %h", $sampled(flagsQ), $sampled(FlagsE));
    end

  cmpNoWrite: assert property (@(posedge clk) disable iff (!rstN)
      isCmpD && quiet ##1 quiet ##1 quiet |=> !RegWriteW)
    else begin
      failCount++;
      $error("mismatch cmp expected 0 actual %b", $sampled(RegWriteW));
    end

  // ==================================================
  // Stores and loads
  // ==================================================
  storeByteLane: assert property (@(posedge clk) disable iff (!rstN)
      isStoreD && InstrD[22] && isAlD && quiet ##1 quiet |=>
      MemWriteM && $onehot(ByteMaskM) && ByteMaskM[resQ[1:0]])
    else begin
      failCount++;
      $error("mismatch storeByte expected lane %0d actual %b%b", $sampled(resQ[1:0]),
             $sampled(MemWriteM), $sampled(ByteMaskM));
    end

  storeWord: assert property (@(posedge clk) disable iff (!rstN)
      isStoreD && !InstrD[22] && isAlD && quiet ##1 quiet |=>
      MemWriteM && ByteMaskM == 4'b1111)
    else begin
      failCount++;
      $error("mismatch storeWord expected 11111 actual %b%b", $sampled(MemWriteM),
             $sampled(ByteMaskM));
    end

  // U bit set means the offset is added, I bit clear means immediate offset
  loadAluOp: assert property (@(posedge clk) disable iff (!rstN)
      isLdrD && quiet |=>
      AluControlE == (instrQ[23] ? aluAdd : aluSub) && AluSrcE == !instrQ[25])
    else begin
      failCount++;
      $error("mismatch loadAlu expected %h/%b actual %h/%b",
             $sampled(instrQ[23] ? aluAdd : aluSub), $sampled(!instrQ[25]),
             $sampled(AluControlE), $sampled(AluSrcE));
    end

  loadWriteback: assert property (@(posedge clk) disable iff (!rstN)
      isLdrD && isAlD && quiet ##1 quiet ##1 quiet |=> MemtoRegW && RegWriteW)
    else begin
      failCount++;
      $error("mismatch loadWb expected 11 actual %b%b", $sampled(MemtoRegW),
             $sampled(RegWriteW));
    end

  // Bubble reaches Memory two edges after the flush
  flushBubble: assert property (@(posedge clk) disable iff (!rstN)
      FlushE ##1 !StallM |=> !(RegWriteM || MemWriteM))
    else begin
      failCount++;
      $error("mismatch flush expected 00 actual %b%b", $sampled(RegWriteM),
             $sampled(MemWriteM));
    end

endmodule

bind armController armControllerAsserts i_armControllerAsserts (.*);

//--- verification/armControllerTb.sv
module armControllerTb import armCtrlPkg::*; ();

  localparam int    TimeoutCycles = 200;       // Tests take about 45
  localparam instrT Nop = 32'hec000000;        // Class 11 decodes to no controls

  logic clk, rstN;
  instrT InstrD;
  flagsT ALUFlagsE;
  logic [31:0] ALUResultE;
  logic StallE, FlushE, StallM, FlushM, StallW, FlushW;
  logic [1:0] RegSrcD, ImmSrcD;
  logic AluSrcE, BranchTakenE, RegWriteM, MemWriteM, MemtoRegM;
  logic MemtoRegW, RegWriteW, PcSrcW;
  aluCtrlT AluControlE;
  flagsT FlagsE;
  byteMaskT ByteMaskM;

  integer seed = 32'h1e73;
  int cycleCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int errorsBefore = 0;    // Assertion failures before the current test

  clockGen i_clockGen (.clk, .rstN);

  armController i_armController (.*);

  // ==================================================
  // Helpers
  // ==================================================
  // aluFlags are the ALU flags of the op now in Execute
  task automatic driveCycle(input instrT instr, input flagsT aluFlags);
    InstrD     = instr;
    ALUFlagsE  = aluFlags;
    ALUResultE = $random(seed);   // Lane pick for stores
    @(negedge clk);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) driveCycle(Nop, 4'h0);
  endtask

  task automatic reportTest(input string name);
    int newErrors;
    newErrors    = i_armController.i_armControllerAsserts.failCount - errorsBefore;
    errorsBefore = i_armController.i_armControllerAsserts.failCount;
    testsRun++;
    if (newErrors != 0) testsFailed++;
    $display("%s: %s, %0d assertion errors", name, (newErrors == 0) ? "ok" : "failed",
             newErrors);
  endtask

  // Run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // ==================================================
  // Tests
  // ==================================================
  initial begin
    InstrD = Nop;
    ALUFlagsE = '0;
    ALUResultE = '0;
    {StallE, FlushE, StallM, FlushM, StallW, FlushW} = '0;
    wait (rstN);
    idleCycles(2);
    reportTest("reset");

    driveCycle(32'hea000004, 4'h0);   // B always
    driveCycle(32'h0a000004, 4'h0);   // BEQ, Z still clear
    driveCycle(32'he3500000, 4'h0);   // CMP r0,#0
    driveCycle(32'h0a000004, 4'h4);   // BEQ after Z set
    idleCycles(4);
    reportTest("branch");

    driveCycle(32'he2921001, 4'h0);   // ADDS r1,r2,#1
    driveCycle(Nop, 4'h9);
    driveCycle(32'he3510005, 4'h0);   // CMP r1,#5
    driveCycle(Nop, 4'h6);
    idleCycles(4);
    reportTest("flags");

    repeat (4) driveCycle(32'he5c10000, 4'h0);   // STRB, random lane
    driveCycle(32'he5810000, 4'h0);              // STR word
    idleCycles(4);
    reportTest("store");

    driveCycle(32'he5910000, 4'h0);   // LDR, U set
    driveCycle(32'he5110000, 4'h0);   // LDR, U clear
    idleCycles(4);
    reportTest("load");

    FlushE = 1'b1;                    // Both dropped on their way into Execute
    driveCycle(32'he5810000, 4'h0);
    driveCycle(32'he2811001, 4'h0);
    FlushE = 1'b0;
    idleCycles(4);
    reportTest("flush");

    $display("Tests run %0d, failed %0d, assertion errors %0d", testsRun, testsFailed,
             errorsBefore);
    if (testsFailed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- armController.f
common/armCtrlPkg.sv
decode/instrDecoder.sv
execute/executeStage.sv
logic/memWbPipe.sv
logic/flagTracker.sv
logic/armController.sv
verification/clockGen.sv
verification/armController_asserts.sv
verification/armControllerTb.sv

//--- Bender.yml
package:
  name: arm_controller

sources:
  - common/armCtrlPkg.sv
  - decode/instrDecoder.sv
  - execute/executeStage.sv
  - logic/memWbPipe.sv
  - logic/flagTracker.sv
  - logic/armController.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/armController_asserts.sv
      - verification/armControllerTb.sv
